//--- fetch_top.f
common/fetch_pkg.sv
common/icache_pkg.sv
common/icache_port_if.sv
hw/fetch_unit.sv
icache/icache_line_store.sv
icache/icache_ctrl.sv
hw/fetch_top.sv
test/fetch_mem_model.sv
test/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the fetch testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -j 0 --top-module fetch_tb \
    -f fetch_top.f --Mdir "$build_dir" -o fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

"./$build_dir/fetch_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "test failed" "$log_file"; then
    exit 1
fi
exit 0

//--- test/fetch_tb.sv
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    localparam logic [31:0] boot_pc       = default_reset_vector;
    localparam logic [31:0] error_lo      = 32'h3000_0400;
    localparam logic [31:0] error_hi      = 32'h3000_040f;
    localparam logic [31:0] loop_base     = 32'h3000_0100;
    localparam int          wait_limit    = 200;
    localparam int          handoff_limit = 100;

    logic        clock;
    logic        reset;
    logic [31:0] redirect_pc;
    logic        redirect_valid;
    logic        hold;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        inst_fault;
    logic        inst_valid;
    logic        inst_ready;
    logic        arready;
    logic        arvalid;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic        rready;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic        stall_error;

    // Written by the monitor only
    int          monitor_errors;
    int          handoff_count;
    int          ar_count;
    logic [31:0] last_pc;
    logic        last_fault;

    // Written by the main sequence only
    int          seed;
    int          check_errors;
    int          test_base;
    int          tests_run;
    int          tests_bad;
    logic        timed_out;
    logic [31:0] held_pc;
    logic [31:0] hits_mid;
    logic [31:0] misses_start;
    int          ar_start;

    fetch_top #(
        .reset_vector (boot_pc)
    ) dut (
        .clock          (clock),
        .reset          (reset),
        .redirect_pc    (redirect_pc),
        .redirect_valid (redirect_valid),
        .hold           (hold),
        .pc             (pc),
        .inst           (inst),
        .inst_fault     (inst_fault),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .arready        (arready),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arburst        (arburst),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .rresp          (rresp),
        .rlast          (rlast),
        .rready         (rready),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    fetch_mem_model memory (
        .clock       (clock),
        .reset       (reset),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arlen       (arlen),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rready      (rready),
        .stall_error (stall_error)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // --------------------
    // Reference model
    // --------------------

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr * 32'h9e37_79b9 + 32'd1;
    endfunction

    function automatic logic in_error_window(input logic [31:0] addr);
        return addr >= error_lo && addr <= error_hi;
    endfunction

    // Hold repeats the pc, else a redirect jumps, else fall through
    function automatic logic [31:0] predict_next_pc(input logic [31:0] cur,
                                                    input logic hold_seen,
                                                    input logic redir_seen,
                                                    input logic [31:0] target);
        if (hold_seen) begin
            return cur;
        end else if (redir_seen) begin
            return target;
        end
        return cur + 32'd4;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // --------------------
    // Comparison process
    // --------------------

    // Samples just after each falling edge, when all inputs have settled
    initial begin : monitor
        logic [31:0] exp_pc;
        logic        hold_seen;
        logic        redir_seen;
        logic [31:0] redir_target;
        exp_pc         = boot_pc;
        hold_seen      = 1'b0;
        redir_seen     = 1'b0;
        redir_target   = '0;
        monitor_errors = 0;
        handoff_count  = 0;
        ar_count       = 0;
        last_pc        = '0;
        last_fault     = 1'b0;
        forever begin
            @(negedge clock);
            #1;
            if (reset) begin
                exp_pc     = boot_pc;
                hold_seen  = 1'b0;
                redir_seen = 1'b0;
            end else begin
                // First request since the last handoff wins
                if (!hold_seen && !redir_seen) begin
                    if (hold) begin
                        hold_seen = 1'b1;
                    end else if (redirect_valid) begin
                        redir_seen   = 1'b1;
                        redir_target = redirect_pc;
                    end
                end
                if (inst_valid && inst_ready) begin
                    if (pc !== exp_pc) begin
                        report_mismatch($sformatf("pc %h, expected %h", pc, exp_pc));
                        monitor_errors++;
                    end
                    if (inst_fault !== in_error_window(exp_pc)) begin
                        report_mismatch($sformatf("inst_fault %b at pc %h", inst_fault, exp_pc));
                        monitor_errors++;
                    end
                    if (!in_error_window(exp_pc) && inst !== mem_word(exp_pc)) begin
                        report_mismatch($sformatf("inst %h at pc %h, expected %h",
                                                  inst, exp_pc, mem_word(exp_pc)));
                        monitor_errors++;
                    end
                    last_pc    = pc;
                    last_fault = inst_fault;
                    handoff_count++;
                    exp_pc     = predict_next_pc(exp_pc, hold_seen, redir_seen, redir_target);
                    hold_seen  = 1'b0;
                    redir_seen = 1'b0;
                end
                // AR handshake at the coming edge, for the line of the pc in flight
                if (arvalid && arready) begin
                    ar_count++;
                    if (arlen !== 8'd3 || arsize !== size_word || arburst !== burst_incr) begin
                        report_mismatch($sformatf("AR len %0d size %0d burst %0d",
                                                  arlen, arsize, arburst));
                        monitor_errors++;
                    end
                    if (araddr !== {exp_pc[31:4], 4'h0}) begin
                        report_mismatch($sformatf("araddr %h, expected line %h",
                                                  araddr, {exp_pc[31:4], 4'h0}));
                        monitor_errors++;
                    end
                end
            end
        end
    end

    // --------------------
    // Stimulus helpers
    // --------------------

    task automatic note_timeout(input string what);
        $display("Timeout: waited more than the cycle limit for %s at time %0t", what, $time);
        timed_out = 1'b1;
        check_errors++;
    endtask

    task automatic wait_inst_valid();
        int cycles;
        cycles = 0;
        while (!timed_out && inst_valid !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                note_timeout("inst_valid");
            end
        end
    endtask

    // Lets count handoffs through, then parks the decode side
    task automatic run_handoffs(input int count, input logic random_ready);
        int target;
        int cycles;
        int rnd;
        target = handoff_count + count;
        cycles = 0;
        while (!timed_out && handoff_count < target) begin
            rnd        = $random(seed);
            inst_ready = random_ready ? rnd[0] : 1'b1;
            @(negedge clock);
            cycles++;
            if (cycles > count * handoff_limit) begin
                note_timeout("handoffs");
            end
        end
        inst_ready = 1'b0;
    endtask

    task automatic pulse_redirect(input logic [31:0] target, input logic with_hold);
        redirect_pc    = target;
        redirect_valid = 1'b1;
        hold           = with_hold;
        @(negedge clock);
        redirect_valid = 1'b0;
        hold           = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int now_errors;
        now_errors = monitor_errors + check_errors;
        tests_run++;
        if (now_errors != test_base) begin
            tests_bad++;
            $display("%s: %0d errors", name, now_errors - test_base);
        end else begin
            $display("%s: ok", name);
        end
        test_base = now_errors;
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        seed           = 32'h10d4_58a5;
        check_errors   = 0;
        test_base      = 0;
        tests_run      = 0;
        tests_bad      = 0;
        timed_out      = 1'b0;
        reset          = 1'b1;
        redirect_pc    = '0;
        redirect_valid = 1'b0;
        hold           = 1'b0;
        inst_ready     = 1'b0;

        repeat (2) begin
            @(negedge clock);
            if (inst_valid !== 1'b0 || arvalid !== 1'b0 || rready !== 1'b0) begin
                report_mismatch("inst_valid, arvalid or rready high during reset");
                check_errors++;
            end
        end
        reset = 1'b0;
        run_handoffs(1, 1'b0);
        if (last_pc !== boot_pc) begin
            report_mismatch($sformatf("first handoff at %h", last_pc));
            check_errors++;
        end
        finish_test("reset and first fetch");

        run_handoffs(40, 1'b1);
        finish_test("sequential fetch with back-pressure");

        wait_inst_valid();
        pulse_redirect(32'h3000_0080, 1'b0);
        run_handoffs(2, 1'b0);
        if (last_pc !== 32'h3000_0080) begin
            report_mismatch($sformatf("redirect gave pc %h", last_pc));
            check_errors++;
        end
        wait_inst_valid();
        pulse_redirect(32'h3000_00c0, 1'b1);
        run_handoffs(1, 1'b0);
        held_pc = last_pc;
        run_handoffs(1, 1'b0);
        if (last_pc !== held_pc) begin
            report_mismatch($sformatf("hold gave pc %h after %h", last_pc, held_pc));
            check_errors++;
        end
        finish_test("redirect and hold");

        // Two lines, eight words, second pass from the cache
        wait_inst_valid();
        pulse_redirect(loop_base, 1'b0);
        run_handoffs(1, 1'b0);
        misses_start = miss_count;
        run_handoffs(7, 1'b0);
        wait_inst_valid();
        pulse_redirect(loop_base, 1'b0);
        run_handoffs(1, 1'b0);
        hits_mid = hit_count;
        ar_start = ar_count;
        run_handoffs(8, 1'b0);
        if (hit_count - hits_mid !== 32'd8 || miss_count - misses_start !== 32'd2) begin
            report_mismatch($sformatf("loop hits %0d, misses %0d",
                                      hit_count - hits_mid, miss_count - misses_start));
            check_errors++;
        end
        if (ar_count != ar_start) begin
            report_mismatch("AR request during the second loop pass");
            check_errors++;
        end
        finish_test("loop from the cache");

        wait_inst_valid();
        pulse_redirect(error_lo, 1'b0);
        run_handoffs(1, 1'b0);
        wait_inst_valid();
        misses_start = miss_count;
        ar_start     = ar_count;
        pulse_redirect(error_lo, 1'b0);
        run_handoffs(1, 1'b0);
        if (last_pc !== error_lo || last_fault !== 1'b1) begin
            report_mismatch($sformatf("pc %h fault %b in error window", last_pc, last_fault));
            check_errors++;
        end
        wait_inst_valid();
        if (miss_count - misses_start !== 32'd1 || ar_count != ar_start + 1) begin
            report_mismatch("faulted line was kept in the cache");
            check_errors++;
        end
        run_handoffs(1, 1'b0);
        if (last_fault !== 1'b1) begin
            report_mismatch("second fetch of the error window without fault");
            check_errors++;
        end
        finish_test("read error and refetch");

        if (stall_error) begin
            $display("Memory model saw rready stay low during a read beat");
            check_errors++;
        end
        $display("%0d tests run, %0d with errors, %0d handoffs, %0d errors in total",
                 tests_run, tests_bad, handoff_count, monitor_errors + check_errors);
        if (monitor_errors + check_errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/fetch_mem_model.sv
`default_nettype none

// AXI read slave for the fetch path, no write channels
module fetch_mem_model
    import fetch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            arvalid,
    output logic            arready,
    input  logic [xlen-1:0] araddr,
    input  logic [7:0]      arlen,
    output logic            rvalid,
    output logic [xlen-1:0] rdata,
    output logic [1:0]      rresp,
    output logic            rlast,
    input  logic            rready,
    output logic            stall_error
);

    localparam logic [1:0]      resp_slverr = 2'b10;
    localparam logic [xlen-1:0] error_lo    = 32'h3000_0400;
    localparam logic [xlen-1:0] error_hi    = 32'h3000_040f;
    localparam int              beat_limit  = 16;

    int              seed;
    int              beats;
    int              wait_cycles;
    logic            accepted;
    logic [xlen-1:0] addr;

    // Memory contents follow the address
    function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] a);
        return a * 32'h9e37_79b9 + 32'd1;
    endfunction

    // 0 to 3 idle cycles
    task automatic random_gap();
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) @(negedge clock);
    endtask

    initial begin
        seed        = 32'h10d4_58a5;
        arready     = 1'b0;
        rvalid      = 1'b0;
        rdata       = '0;
        rresp       = resp_okay;
        rlast       = 1'b0;
        stall_error = 1'b0;
        forever begin
            @(negedge clock);
            if (!reset && arvalid) begin
                // --------------------
                // Address phase
                // --------------------
                random_gap();
                arready = 1'b1;
                addr    = araddr;
                beats   = int'(arlen) + 1;
                @(negedge clock);
                arready = 1'b0;

                // --------------------
                // Data beats
                // --------------------
                for (int i = 0; i < beats; i++) begin
                    random_gap();
                    rvalid = 1'b1;
                    rdata  = mem_word(addr);
                    rresp  = (addr >= error_lo && addr <= error_hi) ? resp_slverr : resp_okay;
                    rlast  = (i == beats - 1);
                    // rready is registered, so its value now holds at the next edge
                    accepted    = 1'b0;
                    wait_cycles = 0;
                    while (!accepted && wait_cycles < beat_limit) begin
                        accepted = rready;
                        @(negedge clock);
                        wait_cycles++;
                    end
                    if (!accepted) begin
                        stall_error = 1'b1;
                    end
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                    addr   = addr + 32'd4;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`default_nettype none

module fetch_top
    import fetch_pkg::*, icache_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = default_reset_vector
) (
    input  logic            clock,
    input  logic            reset,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            redirect_valid,
    input  logic            hold,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] inst,
    output logic            inst_fault,
    output logic            inst_valid,
    input  logic            inst_ready,
    input  logic            arready,
    output logic            arvalid,
    output logic [xlen-1:0] araddr,
    output logic [7:0]      arlen,
    output logic [2:0]      arsize,
    output logic [1:0]      arburst,
    input  logic            rvalid,
    input  logic [xlen-1:0] rdata,
    input  logic [1:0]      rresp,
    input  logic            rlast,
    output logic            rready,
    output logic [31:0]     hit_count,
    output logic [31:0]     miss_count
);

    icache_port_if cache_port ();

    // Controller to line store
    fetch_addr_u     lookup_addr;
    logic            lookup_hit;
    logic [xlen-1:0] lookup_word;
    logic            fill_en;
    fetch_addr_u     fill_addr;
    logic [xlen-1:0] fill_word;
    logic            fill_commit;

    fetch_unit #(
        .reset_vector (reset_vector)
    ) u_fetch_unit (
        .clock          (clock),
        .reset          (reset),
        .redirect_pc    (redirect_pc),
        .redirect_valid (redirect_valid),
        .hold           (hold),
        .pc             (pc),
        .inst           (inst),
        .inst_fault     (inst_fault),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .port           (cache_port.fetch)
    );

    icache_ctrl u_icache_ctrl (
        .clock       (clock),
        .reset       (reset),
        .port        (cache_port.cache),
        .arready     (arready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rready      (rready),
        .hit_count   (hit_count),
        .miss_count  (miss_count),
        .lookup_addr (lookup_addr),
        .lookup_hit  (lookup_hit),
        .lookup_word (lookup_word),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_word   (fill_word),
        .fill_commit (fill_commit)
    );

    icache_line_store u_icache_line_store (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .lookup_hit  (lookup_hit),
        .lookup_word (lookup_word),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_word   (fill_word),
        .fill_commit (fill_commit)
    );

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`default_nettype none

module icache_ctrl
    import fetch_pkg::*, icache_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    icache_port_if.cache    port,
    input  logic            arready,
    output logic            arvalid,
    output logic [xlen-1:0] araddr,
    output logic [7:0]      arlen,
    output logic [2:0]      arsize,
    output logic [1:0]      arburst,
    input  logic            rvalid,
    input  logic [xlen-1:0] rdata,
    input  logic [1:0]      rresp,
    input  logic            rlast,
    output logic            rready,
    output logic [31:0]     hit_count,
    output logic [31:0]     miss_count,
    output fetch_addr_u     lookup_addr,
    input  logic            lookup_hit,
    input  logic [xlen-1:0] lookup_word,
    output logic            fill_en,
    output fetch_addr_u     fill_addr,
    output logic [xlen-1:0] fill_word,
    output logic            fill_commit
);

    refill_state_e          state_q;
    refill_state_e          state_d;
    fetch_addr_u            req_q;
    fetch_addr_u            line_addr;
    logic [offset_bits-1:0] beat_q;
    logic                   err_q;
    logic                   done_q;
    logic [xlen-1:0]        word_q;
    logic                   beat;
    logic                   beat_err;

    assign beat     = (state_q == state_fill) && rvalid;
    assign beat_err = rresp != resp_okay;

    // --------------------
    // Refill FSM
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            state_idle:    if (port.req_valid) state_d = state_lookup;
            state_lookup:  state_d = lookup_hit ? state_idle : state_address;
            state_address: if (arready) state_d = state_fill;
            state_fill:    if (rvalid && rlast) state_d = state_idle;
            default:       state_d = state_idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state_q    <= state_idle;
            beat_q     <= '0;
            err_q      <= 1'b0;
            done_q     <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state_q <= state_d;
            done_q  <= beat && rlast;
            if (state_q == state_address && arready) begin
                beat_q <= '0;
                err_q  <= 1'b0;
            end else if (beat) begin
                beat_q <= beat_q + offset_bits'(1);
                err_q  <= err_q || beat_err;
            end
            if (state_q == state_lookup) begin
                if (lookup_hit) begin
                    hit_count <= hit_count + 32'd1;
                end else begin
                    miss_count <= miss_count + 32'd1;
                end
            end
        end
    end

    // Request address and the wanted word as it goes by
    always_ff @(posedge clock) begin
        if (port.req_valid && port.req_ready) begin
            req_q <= port.req_addr;
        end
        if (beat && beat_q == req_q.f.word) begin
            word_q <= rdata;
        end
    end

    // --------------------
    // AXI read address and data
    // --------------------

    always_comb begin
        line_addr            = req_q;
        line_addr.f.word     = '0;
        line_addr.f.byte_sel = '0;
    end

    assign arvalid = state_q == state_address;
    assign araddr  = line_addr.raw;
    assign arlen   = 8'(words_per_line - 1);
    assign arsize  = size_word;
    assign arburst = burst_incr;
    assign rready  = state_q == state_fill;

    // Beats go into the store in word order
    always_comb begin
        fill_addr        = req_q;
        fill_addr.f.word = beat_q;
    end

    assign fill_en     = beat;
    assign fill_word   = rdata;
    assign fill_commit = beat && rlast && !err_q && !beat_err;
    assign lookup_addr = req_q;

    // --------------------
    // Port side
    // --------------------

    assign port.req_ready = state_q == state_idle;
    assign port.rsp_valid = ((state_q == state_lookup) && lookup_hit) || done_q;
    assign port.rsp_inst  = (state_q == state_lookup) ? lookup_word : word_q;
    assign port.rsp_fault = done_q && err_q;

endmodule

`default_nettype wire

//--- icache/icache_line_store.sv
`default_nettype none

module icache_line_store
    import fetch_pkg::*, icache_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  fetch_addr_u     lookup_addr,
    output logic            lookup_hit,
    output logic [xlen-1:0] lookup_word,
    input  logic            fill_en,
    input  fetch_addr_u     fill_addr,
    input  logic [xlen-1:0] fill_word,
    input  logic            fill_commit
);

    logic [xlen-1:0]     data_mem [line_count][words_per_line];
    logic [tag_bits-1:0] tag_mem  [line_count];
    logic [line_count-1:0] valid_q;

    // --------------------
    // Lookup port
    // --------------------

    assign lookup_hit  = valid_q[lookup_addr.f.index]
                         && (tag_mem[lookup_addr.f.index] == lookup_addr.f.tag);
    assign lookup_word = data_mem[lookup_addr.f.index][lookup_addr.f.word];

    // --------------------
    // Fill port
    // --------------------

    // Line stays invalid while beats arrive, commit makes it live
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill_commit) begin
            valid_q[fill_addr.f.index] <= 1'b1;
        end else if (fill_en) begin
            valid_q[fill_addr.f.index] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en) begin
            data_mem[fill_addr.f.index][fill_addr.f.word] <= fill_word;
        end
        if (fill_commit) begin
            tag_mem[fill_addr.f.index] <= fill_addr.f.tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
#(
    parameter logic [xlen-1:0] reset_vector = default_reset_vector
) (
    input  logic            clock,
    input  logic            reset,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            redirect_valid,
    input  logic            hold,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] inst,
    output logic            inst_fault,
    output logic            inst_valid,
    input  logic            inst_ready,
    icache_port_if.fetch    port
);

    logic            req_valid_q;
    logic            rsp_wait_q;
    logic            hold_q;
    logic            redir_q;
    logic [xlen-1:0] redir_pc_q;

    logic            handoff;
    logic            pending;
    logic            take_hold;
    logic            take_redir;
    logic [xlen-1:0] redir_target;
    logic [xlen-1:0] next_pc;

    assign handoff = inst_valid && inst_ready;
    assign pending = hold_q || redir_q;

    // --------------------
    // Next PC selection
    // --------------------

    // Requests in the handoff cycle itself still count if nothing is latched yet
    always_comb begin
        take_hold    = hold_q || (!pending && hold);
        take_redir   = redir_q || (!pending && !hold && redirect_valid);
        redir_target = redir_q ? redir_pc_q : redirect_pc;
        if (take_hold) begin
            next_pc = pc;
        end else if (take_redir) begin
            next_pc = redir_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // First request wins, hold beats redirect in the same cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hold_q  <= 1'b0;
            redir_q <= 1'b0;
        end else if (handoff) begin
            hold_q  <= 1'b0;
            redir_q <= 1'b0;
        end else if (!pending) begin
            hold_q  <= hold;
            redir_q <= redirect_valid && !hold;
        end
    end

    always_ff @(posedge clock) begin
        if (!pending && !handoff) begin
            redir_pc_q <= redirect_pc;
        end
    end

    // --------------------
    // Request and output control
    // --------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc          <= reset_vector;
            req_valid_q <= 1'b0;
            rsp_wait_q  <= 1'b0;
            inst_valid  <= 1'b0;
        end else begin
            // Issue after reset and right after each handoff
            if (req_valid_q && port.req_ready) begin
                req_valid_q <= 1'b0;
                rsp_wait_q  <= 1'b1;
            end else if (!req_valid_q && !rsp_wait_q && (!inst_valid || handoff)) begin
                req_valid_q <= 1'b1;
            end

            if (port.rsp_valid) begin
                rsp_wait_q <= 1'b0;
                inst_valid <= 1'b1;
            end else if (handoff) begin
                inst_valid <= 1'b0;
            end

            if (handoff) begin
                pc <= next_pc;
            end
        end
    end

    // Decode-side payload
    always_ff @(posedge clock) begin
        if (port.rsp_valid) begin
            inst       <= port.rsp_inst;
            inst_fault <= port.rsp_fault;
        end
    end

    assign port.req_valid    = req_valid_q;
    assign port.req_addr.raw = pc;

endmodule

`default_nettype wire

//--- common/icache_port_if.sv
`default_nettype none

// Fetch unit to cache controller, one request outstanding
interface icache_port_if
    import fetch_pkg::*, icache_pkg::*;
();

    // Request side
    logic            req_valid;
    logic            req_ready;
    fetch_addr_u     req_addr;

    // Response pulse, no ready
    logic            rsp_valid;
    logic [xlen-1:0] rsp_inst;
    logic            rsp_fault;

    modport fetch (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_inst,
        input  rsp_fault
    );

    modport cache (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_inst,
        output rsp_fault
    );

endinterface

`default_nettype wire

//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    import fetch_pkg::*;

    // --------------------
    // Cache geometry
    // --------------------

    parameter int line_count     = 16;
    parameter int words_per_line = 4;
    parameter int index_bits     = $clog2(line_count);
    parameter int offset_bits    = $clog2(words_per_line);
    parameter int tag_bits       = xlen - index_bits - offset_bits - 2;

    // Same fetch address, either as a raw word or split into cache fields
    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [index_bits-1:0]  index;
            logic [offset_bits-1:0] word;
            logic [1:0]             byte_sel;
        } f;
    } fetch_addr_u;

    // Controller states
    typedef enum logic [1:0] {
        state_idle,
        state_lookup,
        state_address,
        state_fill
    } refill_state_e;

endpackage

`default_nettype wire

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // --------------------
    // Core widths
    // --------------------

    parameter int xlen = 32;

    // Boot address of the core
    parameter logic [xlen-1:0] default_reset_vector = 32'h3000_0000;

    // --------------------
    // AXI read encodings
    // --------------------

    // INCR burst type
    parameter logic [1:0] burst_incr = 2'b01;

    // Four bytes per beat
    parameter logic [2:0] size_word = 3'b010;

    // Only OKAY counts as success, EXOKAY and errors do not
    parameter logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire
